//--- design/rot_pkg.sv
// Root-of-trust shared types, register map and boot states
package rot_pkg;

    localparam int APB_ADDR_W  = 12;
    localparam int APB_DATA_W  = 32;
    localparam int MBOX_DEPTH  = 64;
    localparam int MBOX_ADDR_W = $clog2(MBOX_DEPTH);
    localparam int MBOX_LEN_W  = 16;
    localparam int FUSE_WORDS  = 4;
    localparam int FUSE_IDX_W  = $clog2(FUSE_WORDS);
    localparam int ERR_W       = 3;

    typedef logic [APB_ADDR_W-1:0]  apb_addr_t;
    typedef logic [APB_DATA_W-1:0]  apb_data_t;
    typedef logic [MBOX_ADDR_W-1:0] mbox_addr_t;
    typedef logic [MBOX_LEN_W-1:0]  mbox_len_t;
    typedef logic [2:0]             mbox_sel_t;

    // Largest legal DLEN in bytes
    localparam mbox_len_t MBOX_MAX_DLEN = mbox_len_t'(4 * MBOX_DEPTH);

    // Register offsets
    localparam apb_addr_t REG_FUSE_BASE    = 12'h000;
    localparam apb_addr_t REG_FUSE_DONE    = 12'h010;
    localparam apb_addr_t REG_BOOT_STATUS  = 12'h014;
    localparam apb_addr_t REG_BOOT_GO      = 12'h018;
    localparam apb_addr_t REG_ERROR        = 12'h01C;
    localparam apb_addr_t REG_MBOX_LOCK    = 12'h100;
    localparam apb_addr_t REG_MBOX_CMD     = 12'h104;
    localparam apb_addr_t REG_MBOX_DLEN    = 12'h108;
    localparam apb_addr_t REG_MBOX_DATAIN  = 12'h10C;
    localparam apb_addr_t REG_MBOX_DATAOUT = 12'h110;
    localparam apb_addr_t REG_MBOX_EXECUTE = 12'h114;

    // Mailbox register select, word index inside the mailbox window
    localparam mbox_sel_t MBOX_SEL_LOCK    = 3'd0;
    localparam mbox_sel_t MBOX_SEL_CMD     = 3'd1;
    localparam mbox_sel_t MBOX_SEL_DLEN    = 3'd2;
    localparam mbox_sel_t MBOX_SEL_DATAIN  = 3'd3;
    localparam mbox_sel_t MBOX_SEL_DATAOUT = 3'd4;
    localparam mbox_sel_t MBOX_SEL_EXECUTE = 3'd5;

    // Error register bit positions
    localparam int ERR_FUSE_LOCK = 0;
    localparam int ERR_NO_LOCK   = 1;
    localparam int ERR_OVERSIZE  = 2;

    typedef enum logic [2:0] {
        BOOT_IDLE     = 3'd0,
        BOOT_FUSE     = 3'd1,
        BOOT_BRKPOINT = 3'd2,
        BOOT_DONE     = 3'd3
    } boot_state_e;

endpackage

//--- design/rot_apb_regs.sv
// APB target with fuse and error registers, forwarding mailbox accesses
module rot_apb_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rot_pkg::apb_addr_t   paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  rot_pkg::apb_data_t   pwdata,
    input  rot_pkg::boot_state_e boot_state,
    input  rot_pkg::apb_data_t   mbox_rdata,
    input  logic                 mbox_rd_valid,
    input  logic                 err_no_lock,
    input  logic                 err_oversize,
    output rot_pkg::apb_data_t   prdata,
    output logic                 pready,
    output logic                 pslverr,
    output logic                 fuse_done_wr,
    output logic                 go_wr,
    output logic                 mbox_wr,
    output logic                 mbox_rd,
    output rot_pkg::mbox_sel_t   mbox_sel,
    output rot_pkg::apb_data_t   mbox_wdata,
    output logic                 error_fatal,
    output logic                 error_non_fatal
);

    logic                           access;
    logic                           fuse_hit;
    logic                           fuse_wr;
    logic [rot_pkg::FUSE_IDX_W-1:0] fuse_idx;
    logic                           ctrl_hit;
    logic                           mbox_hit;
    logic                           mapped;
    logic                           dataout_rd;
    logic                           rd_wait_q;
    logic [rot_pkg::ERR_W-1:0]      err_q;
    logic [rot_pkg::ERR_W-1:0]      err_set;
    logic [rot_pkg::ERR_W-1:0]      err_clr;
    rot_pkg::apb_data_t             fuse_q [rot_pkg::FUSE_WORDS];

    assign access = psel && penable;

    // Fuse words are word aligned from the base
    assign fuse_hit = (paddr >= rot_pkg::REG_FUSE_BASE)
                   && (paddr < rot_pkg::REG_FUSE_BASE
                               + rot_pkg::apb_addr_t'(4 * rot_pkg::FUSE_WORDS))
                   && (paddr[1:0] == 2'b00);
    assign fuse_idx = paddr[rot_pkg::FUSE_IDX_W+1:2];

    assign ctrl_hit = paddr inside {rot_pkg::REG_FUSE_DONE, rot_pkg::REG_BOOT_STATUS,
                                    rot_pkg::REG_BOOT_GO, rot_pkg::REG_ERROR};

    assign mbox_hit = paddr inside {rot_pkg::REG_MBOX_LOCK, rot_pkg::REG_MBOX_CMD,
                                    rot_pkg::REG_MBOX_DLEN, rot_pkg::REG_MBOX_DATAIN,
                                    rot_pkg::REG_MBOX_DATAOUT, rot_pkg::REG_MBOX_EXECUTE};

    assign mapped = fuse_hit || ctrl_hit || mbox_hit;

    // DATAOUT read waits one cycle for the SRAM
    assign dataout_rd = access && !pwrite && (paddr == rot_pkg::REG_MBOX_DATAOUT);
    assign pready     = access && (!dataout_rd || mbox_rd_valid);
    assign pslverr    = access && !mapped;

    assign fuse_wr      = access && pwrite && fuse_hit;
    assign fuse_done_wr = access && pwrite && (paddr == rot_pkg::REG_FUSE_DONE);
    assign go_wr        = access && pwrite && (paddr == rot_pkg::REG_BOOT_GO);

    // Mailbox forwarding, read issued once per transfer
    assign mbox_wr    = access && pwrite && mbox_hit;
    assign mbox_rd    = access && !pwrite && mbox_hit && !rd_wait_q;
    assign mbox_sel   = paddr[4:2];
    assign mbox_wdata = pwdata;

    always_ff @(posedge clk)
    begin
        if (fuse_wr && (boot_state == rot_pkg::BOOT_FUSE))
        begin
            fuse_q[fuse_idx] <= pwdata;
        end
    end

    always_comb
    begin
        err_set = '0;
        err_set[rot_pkg::ERR_FUSE_LOCK] = fuse_wr && (boot_state != rot_pkg::BOOT_FUSE);
        err_set[rot_pkg::ERR_NO_LOCK]   = err_no_lock;
        err_set[rot_pkg::ERR_OVERSIZE]  = err_oversize;
    end

    // Write one to clear
    assign err_clr = (access && pwrite && (paddr == rot_pkg::REG_ERROR))
                   ? pwdata[rot_pkg::ERR_W-1:0] : '0;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            err_q     <= '0;
            rd_wait_q <= 1'b0;
        end
        else
        begin
            // A new error wins over a clear in the same cycle
            err_q <= (err_q & ~err_clr) | err_set;
            if (pready)
            begin
                rd_wait_q <= 1'b0;
            end
            else if (dataout_rd)
            begin
                rd_wait_q <= 1'b1;
            end
        end
    end

    // Read data mux, unmapped offsets read zero
    always_comb
    begin
        prdata = '0;
        if (access && !pwrite)
        begin
            if (fuse_hit)
            begin
                prdata = fuse_q[fuse_idx];
            end
            else if (mbox_hit)
            begin
                prdata = mbox_rdata;
            end
            else if (paddr == rot_pkg::REG_BOOT_STATUS)
            begin
                prdata = rot_pkg::apb_data_t'(boot_state);
            end
            else if (paddr == rot_pkg::REG_ERROR)
            begin
                prdata = rot_pkg::apb_data_t'(err_q);
            end
        end
    end

    assign error_fatal     = err_q[rot_pkg::ERR_OVERSIZE];
    assign error_non_fatal = err_q[rot_pkg::ERR_FUSE_LOCK] | err_q[rot_pkg::ERR_NO_LOCK];

endmodule

//--- design/rot_boot_fsm.sv
// Boot sequencer from reset through fuse loading and breakpoint to mailbox ready
module rot_boot_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 BootFSM_BrkPoint,
    input  logic                 fuse_done_wr,
    input  logic                 go_wr,
    output rot_pkg::boot_state_e boot_state,
    output logic                 ready_for_fuses,
    output logic                 ready_for_mb_processing
);

    rot_pkg::boot_state_e state_q;
    rot_pkg::boot_state_e state_d;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            rot_pkg::BOOT_IDLE:
            begin
                state_d = rot_pkg::BOOT_FUSE;
            end
            rot_pkg::BOOT_FUSE:
            begin
                // Strap is sampled as the fuse phase closes
                if (fuse_done_wr)
                begin
                    state_d = BootFSM_BrkPoint ? rot_pkg::BOOT_BRKPOINT
                                               : rot_pkg::BOOT_DONE;
                end
            end
            rot_pkg::BOOT_BRKPOINT:
            begin
                if (go_wr)
                begin
                    state_d = rot_pkg::BOOT_DONE;
                end
            end
            rot_pkg::BOOT_DONE:
            begin
                state_d = rot_pkg::BOOT_DONE;
            end
            default:
            begin
                state_d = rot_pkg::BOOT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q <= rot_pkg::BOOT_IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    // Readiness decoded from registered state
    assign boot_state              = state_q;
    assign ready_for_fuses         = (state_q == rot_pkg::BOOT_FUSE);
    assign ready_for_mb_processing = (state_q == rot_pkg::BOOT_DONE);

endmodule

//--- design/rot_mbox.sv
// Mailbox with lock, command, length, data pointers and external SRAM port
module rot_mbox (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mbox_wr,
    input  logic                mbox_rd,
    input  rot_pkg::mbox_sel_t  mbox_sel,
    input  rot_pkg::apb_data_t  mbox_wdata,
    input  logic                mbox_ready,
    input  rot_pkg::apb_data_t  mbox_sram_rdata,
    output rot_pkg::apb_data_t  mbox_rdata,
    output logic                mbox_rd_valid,
    output logic                mailbox_data_avail,
    output logic                err_no_lock,
    output logic                err_oversize,
    output logic                mbox_sram_cs,
    output logic                mbox_sram_we,
    output rot_pkg::mbox_addr_t mbox_sram_addr,
    output rot_pkg::apb_data_t  mbox_sram_wdata
);

    logic                lock_q;
    logic                exec_q;
    logic                rd_valid_q;
    rot_pkg::apb_data_t  cmd_q;
    rot_pkg::mbox_len_t  dlen_q;
    rot_pkg::mbox_addr_t wr_ptr_q;
    rot_pkg::mbox_addr_t rd_ptr_q;
    logic                needs_lock;
    logic                lock_take;
    logic                cmd_wr;
    logic                dlen_wr;
    logic                datain_wr;
    logic                dataout_rd;
    logic                exec_wr;
    logic                exec_set;
    logic                exec_clr;
    logic                too_long;

    // Registers that only the lock holder may touch
    assign needs_lock = (mbox_wr || mbox_rd)
                     && (mbox_sel inside {rot_pkg::MBOX_SEL_CMD, rot_pkg::MBOX_SEL_DLEN,
                                          rot_pkg::MBOX_SEL_DATAIN, rot_pkg::MBOX_SEL_EXECUTE});
    assign err_no_lock = needs_lock && !lock_q;

    // Lock is granted only once boot is done
    assign lock_take = mbox_rd && (mbox_sel == rot_pkg::MBOX_SEL_LOCK) && mbox_ready && !lock_q;

    assign cmd_wr     = mbox_wr && lock_q && (mbox_sel == rot_pkg::MBOX_SEL_CMD);
    assign dlen_wr    = mbox_wr && lock_q && (mbox_sel == rot_pkg::MBOX_SEL_DLEN);
    assign datain_wr  = mbox_wr && lock_q && (mbox_sel == rot_pkg::MBOX_SEL_DATAIN);
    assign exec_wr    = mbox_wr && lock_q && (mbox_sel == rot_pkg::MBOX_SEL_EXECUTE);
    assign dataout_rd = mbox_rd && (mbox_sel == rot_pkg::MBOX_SEL_DATAOUT);

    assign too_long     = dlen_q > rot_pkg::MBOX_MAX_DLEN;
    assign exec_set     = exec_wr && mbox_wdata[0] && !too_long;
    assign err_oversize = exec_wr && mbox_wdata[0] && too_long;
    assign exec_clr     = exec_wr && !mbox_wdata[0];

    // SRAM port
    assign mbox_sram_cs    = datain_wr || dataout_rd;
    assign mbox_sram_we    = datain_wr;
    assign mbox_sram_addr  = datain_wr ? wr_ptr_q : rd_ptr_q;
    assign mbox_sram_wdata = mbox_wdata;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            lock_q     <= 1'b0;
            exec_q     <= 1'b0;
            rd_valid_q <= 1'b0;
            dlen_q     <= '0;
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
        end
        else
        begin
            rd_valid_q <= dataout_rd;
            if (lock_take)
            begin
                lock_q <= 1'b1;
            end
            else if (exec_clr)
            begin
                lock_q <= 1'b0;
            end
            if (exec_set)
            begin
                exec_q <= 1'b1;
            end
            else if (exec_clr)
            begin
                exec_q <= 1'b0;
            end
            if (dlen_wr)
            begin
                dlen_q <= rot_pkg::mbox_len_t'(mbox_wdata);
            end
            // Clearing execute rewinds both pointers
            if (exec_clr)
            begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
            end
            else
            begin
                if (datain_wr)
                begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
                if (dataout_rd)
                begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (cmd_wr)
        begin
            cmd_q <= mbox_wdata;
        end
    end

    always_comb
    begin
        case (mbox_sel)
            rot_pkg::MBOX_SEL_LOCK:    mbox_rdata = {31'b0, lock_q | ~mbox_ready};
            rot_pkg::MBOX_SEL_CMD:     mbox_rdata = cmd_q;
            rot_pkg::MBOX_SEL_DLEN:    mbox_rdata = rot_pkg::apb_data_t'(dlen_q);
            rot_pkg::MBOX_SEL_DATAOUT: mbox_rdata = mbox_sram_rdata;
            rot_pkg::MBOX_SEL_EXECUTE: mbox_rdata = {31'b0, exec_q};
            default:                   mbox_rdata = '0;
        endcase
    end

    assign mbox_rd_valid      = rd_valid_q;
    assign mailbox_data_avail = exec_q;

endmodule

//--- design/rot_top.sv
// Root-of-trust top joining the APB registers, boot FSM and mailbox
module rot_top (
    input  logic                clk,
    input  logic                rst_n,
    input  rot_pkg::apb_addr_t  paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  rot_pkg::apb_data_t  pwdata,
    output rot_pkg::apb_data_t  prdata,
    output logic                pready,
    output logic                pslverr,
    input  logic                BootFSM_BrkPoint,
    output logic                mbox_sram_cs,
    output logic                mbox_sram_we,
    output rot_pkg::mbox_addr_t mbox_sram_addr,
    output rot_pkg::apb_data_t  mbox_sram_wdata,
    input  rot_pkg::apb_data_t  mbox_sram_rdata,
    output logic                ready_for_fuses,
    output logic                ready_for_mb_processing,
    output logic                mailbox_data_avail,
    output logic                error_fatal,
    output logic                error_non_fatal
);

    rot_pkg::boot_state_e boot_state;
    logic                 fuse_done_wr;
    logic                 go_wr;
    logic                 mbox_wr;
    logic                 mbox_rd;
    rot_pkg::mbox_sel_t   mbox_sel;
    rot_pkg::apb_data_t   mbox_wdata;
    rot_pkg::apb_data_t   mbox_rdata;
    logic                 mbox_rd_valid;
    logic                 err_no_lock;
    logic                 err_oversize;

    rot_apb_regs u_regs (
        .clk(clk), .rst_n(rst_n),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .boot_state(boot_state),
        .mbox_rdata(mbox_rdata), .mbox_rd_valid(mbox_rd_valid),
        .err_no_lock(err_no_lock), .err_oversize(err_oversize),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .fuse_done_wr(fuse_done_wr), .go_wr(go_wr),
        .mbox_wr(mbox_wr), .mbox_rd(mbox_rd), .mbox_sel(mbox_sel), .mbox_wdata(mbox_wdata),
        .error_fatal(error_fatal), .error_non_fatal(error_non_fatal)
    );

    rot_boot_fsm u_boot_fsm (
        .clk(clk), .rst_n(rst_n),
        .BootFSM_BrkPoint(BootFSM_BrkPoint),
        .fuse_done_wr(fuse_done_wr), .go_wr(go_wr),
        .boot_state(boot_state),
        .ready_for_fuses(ready_for_fuses),
        .ready_for_mb_processing(ready_for_mb_processing)
    );

    // Mailbox opens once boot is done
    rot_mbox u_mbox (
        .clk(clk), .rst_n(rst_n),
        .mbox_wr(mbox_wr), .mbox_rd(mbox_rd), .mbox_sel(mbox_sel), .mbox_wdata(mbox_wdata),
        .mbox_ready(ready_for_mb_processing),
        .mbox_sram_rdata(mbox_sram_rdata),
        .mbox_rdata(mbox_rdata), .mbox_rd_valid(mbox_rd_valid),
        .mailbox_data_avail(mailbox_data_avail),
        .err_no_lock(err_no_lock), .err_oversize(err_oversize),
        .mbox_sram_cs(mbox_sram_cs), .mbox_sram_we(mbox_sram_we),
        .mbox_sram_addr(mbox_sram_addr), .mbox_sram_wdata(mbox_sram_wdata)
    );

endmodule

//--- test/rot_tb_sram.sv
// Mailbox SRAM model with synchronous read, serving the DUT SRAM port
module rot_tb_sram (
    input  logic                clk,
    input  logic                cs,
    input  logic                we,
    input  rot_pkg::mbox_addr_t addr,
    input  rot_pkg::apb_data_t  wdata,
    output rot_pkg::apb_data_t  rdata
);

    timeunit 1ns;
    timeprecision 1ps;

    rot_pkg::apb_data_t mem [rot_pkg::MBOX_DEPTH];

    // Fill pattern carries the full word address
    initial
    begin
        for (int i = 0; i < rot_pkg::MBOX_DEPTH; i++)
        begin
            mem[i] = 32'hA5A5_0000 | rot_pkg::apb_data_t'(i);
        end
        rdata = '0;
    end

    always @(posedge clk)
    begin
        if (cs)
        begin
            if (we)
            begin
                mem[addr] <= wdata;
            end
            else
            begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

//--- test/rot_tb_assert.sv
// Concurrent checks on the APB handshake and the status outputs of the DUT
module rot_tb_assert (
    input logic clk,
    input logic rst_n,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic ready_for_fuses,
    input logic ready_for_mb_processing,
    input logic mailbox_data_avail,
    input logic error_fatal
);

    timeunit 1ns;
    timeprecision 1ps;

    // Count of failed assertions
    int unsigned failures = 0;

    a_pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        pready |-> (psel && penable))
        else
        begin
            $error("pready high outside an access phase");
            failures++;
        end

    a_pslverr_with_pready: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> pready)
        else
        begin
            $error("pslverr high without pready");
            failures++;
        end

    a_ready_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(ready_for_fuses && ready_for_mb_processing))
        else
        begin
            $error("fuse and mailbox readiness high together");
            failures++;
        end

    a_fatal_blocks_avail: assert property (@(posedge clk) disable iff (!rst_n)
        error_fatal |-> !mailbox_data_avail)
        else
        begin
            $error("mailbox data available during a fatal error");
            failures++;
        end

endmodule

bind rot_top rot_tb_assert u_assert (
    .clk(clk),
    .rst_n(rst_n),
    .psel(psel),
    .penable(penable),
    .pready(pready),
    .pslverr(pslverr),
    .ready_for_fuses(ready_for_fuses),
    .ready_for_mb_processing(ready_for_mb_processing),
    .mailbox_data_avail(mailbox_data_avail),
    .error_fatal(error_fatal)
);

//--- test/rot_tb.sv
// Testbench top driving the root-of-trust DUT over APB through directed tests
module rot_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam time CLK_PERIOD      = 100;
    localparam int  RESET_CYCLES    = 8;
    localparam int  NUM_TESTS       = 6;
    localparam int  CYCLES_PER_TEST = 400;
    localparam int  APB_WAIT_LIMIT  = 16;
    localparam int  MBOX_WORDS      = 8;
    localparam time WATCHDOG_TIME   = NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD;

    logic                clk;
    logic                rst_n;
    rot_pkg::apb_addr_t  paddr;
    logic                psel;
    logic                penable;
    logic                pwrite;
    rot_pkg::apb_data_t  pwdata;
    rot_pkg::apb_data_t  prdata;
    logic                pready;
    logic                pslverr;
    logic                BootFSM_BrkPoint;
    logic                mbox_sram_cs;
    logic                mbox_sram_we;
    rot_pkg::mbox_addr_t mbox_sram_addr;
    rot_pkg::apb_data_t  mbox_sram_wdata;
    rot_pkg::apb_data_t  mbox_sram_rdata;
    logic                ready_for_fuses;
    logic                ready_for_mb_processing;
    logic                mailbox_data_avail;
    logic                error_fatal;
    logic                error_non_fatal;

    string               test_name;
    int                  errors;
    int                  errors_at_start;
    int                  tests_run;
    int                  tests_failed;
    rot_pkg::apb_data_t  fuse_words [rot_pkg::FUSE_WORDS];

    rot_top DUT (.*);

    rot_tb_sram sram_model (
        .clk(clk), .cs(mbox_sram_cs), .we(mbox_sram_we),
        .addr(mbox_sram_addr), .wdata(mbox_sram_wdata), .rdata(mbox_sram_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_TIME);
        $display("Timeout: the tests did not finish within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("TEST FAIL");
        $finish;
    end

    task automatic check_word(input rot_pkg::apb_data_t expected,
                              input rot_pkg::apb_data_t actual);
        if (actual !== expected)
        begin
            $display("MISMATCH %s: expected 0x%08h, actual 0x%08h", test_name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_state(input rot_pkg::boot_state_e expected,
                               input rot_pkg::boot_state_e actual);
        if (actual !== expected)
        begin
            $display("MISMATCH %s: expected %s, actual %s", test_name, expected.name(),
                     actual.name());
            errors++;
        end
    endtask

    task automatic check_flag(input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("MISMATCH %s: expected %b, actual %b", test_name, expected, actual);
            errors++;
        end
    endtask

    // Setup and access phases start on falling edges
    // Response sampled a quarter period later
    task automatic apb_transfer(input rot_pkg::apb_addr_t addr, input logic write,
                                input rot_pkg::apb_data_t wdata,
                                output rot_pkg::apb_data_t rdata, output logic slverr);
        int   cycles;
        logic done;
        @(negedge clk);
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        cycles  = 0;
        done    = 1'b0;
        rdata   = '0;
        slverr  = 1'b0;
        while (!done)
        begin
            #(CLK_PERIOD / 4);
            if (pready)
            begin
                rdata  = prdata;
                slverr = pslverr;
                done   = 1'b1;
            end
            else if (cycles == APB_WAIT_LIMIT)
            begin
                $display("%s: APB transfer at 0x%03h never completed", test_name, addr);
                errors++;
                done = 1'b1;
            end
            cycles++;
            @(negedge clk);
        end
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input rot_pkg::apb_addr_t addr, input rot_pkg::apb_data_t data,
                             output logic slverr);
        rot_pkg::apb_data_t unused;
        apb_transfer(addr, 1'b1, data, unused, slverr);
    endtask

    task automatic apb_read(input rot_pkg::apb_addr_t addr, output rot_pkg::apb_data_t data,
                            output logic slverr);
        apb_transfer(addr, 1'b0, '0, data, slverr);
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == errors_at_start)
        begin
            $display("%s: passed", test_name);
        end
        else
        begin
            $display("%s: failed with %0d errors", test_name, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    // Holds reset, checks the idle outputs, then releases it
    task automatic apply_reset(input logic brk);
        @(negedge clk);
        rst_n            = 1'b0;
        BootFSM_BrkPoint = brk;
        repeat (RESET_CYCLES) @(negedge clk);
        check_flag(1'b0, ready_for_fuses);
        check_flag(1'b0, ready_for_mb_processing);
        check_flag(1'b0, mailbox_data_avail);
        check_flag(1'b0, error_fatal);
        check_flag(1'b0, error_non_fatal);
        check_flag(1'b0, pready);
        check_flag(1'b0, pslverr);
        check_flag(1'b0, mbox_sram_cs);
        rst_n = 1'b1;
        @(negedge clk);
    endtask

    task automatic boot_without_breakpoint();
        rot_pkg::apb_data_t rd;
        logic               err;
        begin_test("boot_no_brk");
        apply_reset(1'b0);
        check_flag(1'b1, ready_for_fuses);
        apb_read(rot_pkg::REG_BOOT_STATUS, rd, err);
        check_state(rot_pkg::BOOT_FUSE, rot_pkg::boot_state_e'(rd[2:0]));
        for (int i = 0; i < rot_pkg::FUSE_WORDS; i++)
        begin
            fuse_words[i] = $urandom();
            apb_write(rot_pkg::REG_FUSE_BASE + rot_pkg::apb_addr_t'(4 * i), fuse_words[i], err);
        end
        for (int i = 0; i < rot_pkg::FUSE_WORDS; i++)
        begin
            apb_read(rot_pkg::REG_FUSE_BASE + rot_pkg::apb_addr_t'(4 * i), rd, err);
            check_word(fuse_words[i], rd);
        end
        apb_write(rot_pkg::REG_FUSE_DONE, 32'h1, err);
        check_flag(1'b0, ready_for_fuses);
        check_flag(1'b1, ready_for_mb_processing);
        apb_read(rot_pkg::REG_BOOT_STATUS, rd, err);
        check_state(rot_pkg::BOOT_DONE, rot_pkg::boot_state_e'(rd[2:0]));
        end_test();
    endtask

    task automatic fuse_lock_error();
        rot_pkg::apb_data_t rd;
        logic               err;
        begin_test("fuse_lock");
        apb_write(rot_pkg::REG_FUSE_BASE, ~fuse_words[0], err);
        apb_read(rot_pkg::REG_FUSE_BASE, rd, err);
        check_word(fuse_words[0], rd);
        apb_read(rot_pkg::REG_ERROR, rd, err);
        check_word(32'h1, rd);
        check_flag(1'b1, error_non_fatal);
        apb_write(rot_pkg::REG_ERROR, 32'h1, err);
        apb_read(rot_pkg::REG_ERROR, rd, err);
        check_word(32'h0, rd);
        check_flag(1'b0, error_non_fatal);
        end_test();
    endtask

    task automatic breakpoint_hold();
        rot_pkg::apb_data_t rd;
        logic               err;
        begin_test("breakpoint");
        apply_reset(1'b1);
        apb_write(rot_pkg::REG_FUSE_DONE, 32'h1, err);
        apb_read(rot_pkg::REG_BOOT_STATUS, rd, err);
        check_state(rot_pkg::BOOT_BRKPOINT, rot_pkg::boot_state_e'(rd[2:0]));
        check_flag(1'b0, ready_for_mb_processing);
        apb_write(rot_pkg::REG_BOOT_GO, 32'h1, err);
        apb_read(rot_pkg::REG_BOOT_STATUS, rd, err);
        check_state(rot_pkg::BOOT_DONE, rot_pkg::boot_state_e'(rd[2:0]));
        check_flag(1'b1, ready_for_mb_processing);
        end_test();
    endtask

    task automatic mailbox_round_trip();
        rot_pkg::apb_data_t rd;
        rot_pkg::apb_data_t cmd;
        rot_pkg::apb_data_t words [MBOX_WORDS];
        logic               err;
        begin_test("mbox_round_trip");
        apb_read(rot_pkg::REG_MBOX_LOCK, rd, err);
        check_word(32'h0, rd);
        apb_read(rot_pkg::REG_MBOX_LOCK, rd, err);
        check_word(32'h1, rd);
        cmd = $urandom();
        apb_write(rot_pkg::REG_MBOX_CMD, cmd, err);
        apb_read(rot_pkg::REG_MBOX_CMD, rd, err);
        check_word(cmd, rd);
        apb_write(rot_pkg::REG_MBOX_DLEN, 4 * MBOX_WORDS, err);
        for (int i = 0; i < MBOX_WORDS; i++)
        begin
            words[i] = $urandom();
            apb_write(rot_pkg::REG_MBOX_DATAIN, words[i], err);
        end
        apb_write(rot_pkg::REG_MBOX_EXECUTE, 32'h1, err);
        check_flag(1'b1, mailbox_data_avail);
        for (int i = 0; i < MBOX_WORDS; i++)
        begin
            apb_read(rot_pkg::REG_MBOX_DATAOUT, rd, err);
            check_word(words[i], rd);
            check_word(words[i], sram_model.mem[i]);
        end
        apb_write(rot_pkg::REG_MBOX_EXECUTE, 32'h0, err);
        check_flag(1'b0, mailbox_data_avail);
        apb_read(rot_pkg::REG_MBOX_LOCK, rd, err);
        check_word(32'h0, rd);
        // Release again so the next test starts unlocked
        apb_write(rot_pkg::REG_MBOX_EXECUTE, 32'h0, err);
        end_test();
    endtask

    task automatic mailbox_misuse();
        rot_pkg::apb_data_t rd;
        rot_pkg::apb_data_t snapshot [rot_pkg::MBOX_DEPTH];
        logic               err;
        begin_test("mbox_misuse");
        for (int i = 0; i < rot_pkg::MBOX_DEPTH; i++)
        begin
            snapshot[i] = sram_model.mem[i];
        end
        apb_write(rot_pkg::REG_MBOX_DATAIN, $urandom(), err);
        for (int i = 0; i < rot_pkg::MBOX_DEPTH; i++)
        begin
            check_word(snapshot[i], sram_model.mem[i]);
        end
        apb_read(rot_pkg::REG_ERROR, rd, err);
        check_word(32'h2, rd);
        check_flag(1'b1, error_non_fatal);
        apb_write(rot_pkg::REG_ERROR, 32'h2, err);
        // Oversize length at execute
        apb_read(rot_pkg::REG_MBOX_LOCK, rd, err);
        check_word(32'h0, rd);
        apb_write(rot_pkg::REG_MBOX_DLEN, 4 * rot_pkg::MBOX_DEPTH + 4, err);
        apb_write(rot_pkg::REG_MBOX_EXECUTE, 32'h1, err);
        check_flag(1'b1, error_fatal);
        check_flag(1'b0, mailbox_data_avail);
        apb_read(rot_pkg::REG_ERROR, rd, err);
        check_word(32'h4, rd);
        apb_write(rot_pkg::REG_MBOX_EXECUTE, 32'h0, err);
        apb_write(rot_pkg::REG_ERROR, 32'h4, err);
        check_flag(1'b0, error_fatal);
        end_test();
    endtask

    task automatic unmapped_offset();
        rot_pkg::apb_data_t rd;
        logic               err;
        begin_test("unmapped");
        apb_write(12'h200, $urandom(), err);
        check_flag(1'b1, err);
        apb_read(12'h200, rd, err);
        check_flag(1'b1, err);
        check_word(32'h0, rd);
        apb_read(12'h020, rd, err);
        check_flag(1'b1, err);
        check_word(32'h0, rd);
        apb_read(rot_pkg::REG_BOOT_STATUS, rd, err);
        check_flag(1'b0, err);
        end_test();
    endtask

    initial
    begin
        rst_n            = 1'b0;
        paddr            = '0;
        psel             = 1'b0;
        penable          = 1'b0;
        pwrite           = 1'b0;
        pwdata           = '0;
        BootFSM_BrkPoint = 1'b0;
        errors           = 0;
        tests_run        = 0;
        tests_failed     = 0;
        test_name        = "init";
        void'($urandom(39));

        boot_without_breakpoint();
        fuse_lock_error();
        breakpoint_hold();
        mailbox_round_trip();
        mailbox_misuse();
        unmapped_offset();

        errors = errors + int'(DUT.u_assert.failures);
        $display("Tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, DUT.u_assert.failures);
        if (errors == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
design/rot_pkg.sv
design/rot_apb_regs.sv
design/rot_boot_fsm.sv
design/rot_mbox.sv
design/rot_top.sv
test/rot_tb_sram.sv
test/rot_tb_assert.sv
test/rot_tb.sv
